//--- Makefile
# Verilator build and run of the block-transform testbench
VERILATOR ?= verilator
TOP       ?= block_xform_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), search $(LOG) for the fail message"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- block_xform_sva.sv
/* memory and sequencer checks, one module bound to dpmem and to fetch_addr_gen
   inputs a bound block lacks are tied to values that keep those checks idle */

`timescale 1ns/100ps

module block_xform_sva #(
  parameter int ADDR_WIDTH = sxp_mem_pkg::ADDR_W,
  parameter int MEM_SIZE   = 1024
) (
  input logic                      clk,
  input logic                      reset_b,
  input logic                      wea,
  input logic                      web,
  input logic [ADDR_WIDTH-1:0]     addra,
  input logic [ADDR_WIDTH-1:0]     addrb,
  input logic                      busy,
  input logic                      done,
  input sxp_mem_pkg::fetch_state_t state
);

  // same word on both ports during a write gives an x read
  no_collision: assert property (@(posedge clk) disable iff (!reset_b)
    (wea || web) |-> (addra != addrb))
    else $error("port a and port b on the same word during a write");

  wr_range_a: assert property (@(posedge clk) disable iff (!reset_b)
    wea |-> (addra < MEM_SIZE))
    else $error("port a write outside the memory, dropped");

  wr_range_b: assert property (@(posedge clk) disable iff (!reset_b)
    web |-> (addrb < MEM_SIZE))
    else $error("port b write outside the memory, dropped");

  done_in_busy: assert property (@(posedge clk) disable iff (!reset_b)
    done |-> busy)
    else $error("done outside a command");

  // write back must not finish before every source address has gone out
  done_in_drain: assert property (@(posedge clk) disable iff (!reset_b)
    done |-> (state == sxp_mem_pkg::ST_DRAIN))
    else $error("done while the sequencer was not draining");

  busy_falls_after_done: assert property (@(posedge clk) disable iff (!reset_b)
    $fell(busy) |-> $past(done))
    else $error("busy fell without a done pulse");

endmodule

bind dpmem block_xform_sva #(.ADDR_WIDTH(ADDR_WIDTH), .MEM_SIZE(MEM_SIZE)) u_mem_sva (
  .clk(clk), .reset_b(reset_b), .wea(wea), .web(web), .addra(addra), .addrb(addrb),
  .busy(1'b1), .done(1'b0), .state(sxp_mem_pkg::ST_RUN)
);

bind fetch_addr_gen block_xform_sva #(.ADDR_WIDTH(ADDR_WIDTH)) u_fsm_sva (
  .clk(clk), .reset_b(reset_b), .wea(1'b0), .web(1'b0), .addra('0), .addrb('0),
  .busy(busy), .done(done), .state(state)
);

//--- block_xform_tb.sv
/* testbench for block_xform_top, fills the whole memory before the first command
   source and destination ranges sit in opposite halves so they never overlap */

`timescale 1ns/100ps

module block_xform_tb;

  localparam int MEM_WORDS = 1024;
  localparam int MAX_LEN   = 64;                 // longest random command
  localparam int LIMIT     = 200;                // cycles allowed for any one wait

  logic                   clk;
  logic                   reset_b;
  logic                   host_we;
  logic                   host_re;
  logic                   host_rvalid;
  logic                   start;
  logic                   busy;
  logic                   done;
  sxp_mem_pkg::addr_t     host_addr;
  sxp_mem_pkg::addr_t     src_base;
  sxp_mem_pkg::addr_t     dst_base;
  sxp_mem_pkg::word_t     host_wdata;
  sxp_mem_pkg::word_t     host_rdata;
  sxp_mem_pkg::word_t     operand;
  sxp_mem_pkg::len_t      length;
  sxp_mem_pkg::xform_op_t op;

  sxp_mem_pkg::word_t     shadow [0:MEM_WORDS-1];  // expected memory contents
  sxp_mem_pkg::addr_t     read_q [$];              // host reads still owed data
  logic [31:0]            lcg_state = 32'hd8561510;
  int                     checks = 0;
  int                     errors = 0;
  int                     done_pulses = 0;
  int                     commands = 0;

  block_xform_top #(.ADDR_WIDTH(sxp_mem_pkg::ADDR_W), .MEM_SIZE(MEM_WORDS)) uut (
    .clk(clk), .reset_b(reset_b), .host_we(host_we), .host_re(host_re),
    .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
    .host_rvalid(host_rvalid), .start(start), .src_base(src_base), .dst_base(dst_base),
    .length(length), .op(op), .operand(operand), .busy(busy), .done(done)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;                       // 10 ns period
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected word for one element
  function automatic sxp_mem_pkg::word_t ref_xform(input sxp_mem_pkg::xform_op_t f,
                                                   input sxp_mem_pkg::word_t w,
                                                   input sxp_mem_pkg::word_t k);
    sxp_mem_pkg::word_t r;
    int b;
    r = w;
    case (f)
      sxp_mem_pkg::OP_ADD: r = w + k;
      sxp_mem_pkg::OP_XOR: r = w ^ k;
      sxp_mem_pkg::OP_INV: r = w ^ 32'hffff_ffff;
      sxp_mem_pkg::OP_BSWAP:
        for (b = 0; b < 4; b++)
          r[8*b +: 8] = w[8*(3-b) +: 8];        // byte b takes byte 3-b
      default: r = w;
    endcase
    return r;
  endfunction

  task automatic check_word(input string name, input sxp_mem_pkg::word_t got,
                            input sxp_mem_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("no %s within %0d cycles, run stopped", what, LIMIT);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %-26s %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  // read data compare, one entry of read_q per host_rvalid
  always @(negedge clk)
  begin : compare_reads
    sxp_mem_pkg::addr_t a;
    if (reset_b && done === 1'b1)
      done_pulses++;
    if (reset_b && host_rvalid === 1'b1)
    begin
      if (read_q.size() == 0)
      begin
        errors++;
        $display("host_rvalid was high with no host read outstanding");
      end
      else
      begin
        a = read_q.pop_front();
        check_word($sformatf("host_rdata @%h", a), host_rdata, shadow[a]);
      end
    end
  end

  task automatic host_write(input sxp_mem_pkg::addr_t a, input sxp_mem_pkg::word_t d);
    host_we    = 1'b1;
    host_addr  = a;
    host_wdata = d;
    shadow[a]  = d;
    @(negedge clk);
    host_we = 1'b0;
  endtask

  task automatic settle_writes(input sxp_mem_pkg::addr_t park);
    host_addr = park;                            // port a off the words in flight
    repeat (3) @(negedge clk);                   // write lands three edges on
  endtask

  task automatic host_read(input sxp_mem_pkg::addr_t a);
    host_re   = 1'b1;
    host_addr = a;
    read_q.push_back(a);
    @(negedge clk);
    host_re = 1'b0;
    check_flag("host_rvalid", host_rvalid, 1'b1);  // one cycle after host_re
  endtask

  task automatic readback(input int base, input int n);
    int i;
    int t;
    for (i = 0; i < n; i++)
      host_read(sxp_mem_pkg::addr_t'(base + i));
    t = 0;
    while (read_q.size() != 0 && t < LIMIT)
    begin
      @(negedge clk);
      t++;
    end
    if (read_q.size() != 0)
      stop_on_timeout("host read data");
  endtask

  // strobes the engine must ignore while busy
  task automatic drive_stray_strobes();
    logic [31:0] r;
    r          = next_rand();
    start      = r[0];
    host_we    = r[1];
    host_re    = r[2];
    host_addr  = sxp_mem_pkg::addr_t'(next_rand());
    host_wdata = next_rand();
    src_base   = sxp_mem_pkg::addr_t'(next_rand());
    length     = sxp_mem_pkg::len_t'(next_rand());
  endtask

  task automatic run_command(input int src, input int dst, input int len,
                             input sxp_mem_pkg::xform_op_t f,
                             input sxp_mem_pkg::word_t k, input bit stray);
    int lat;
    int i;
    check_flag("busy before start", busy, 1'b0);
    start    = 1'b1;
    src_base = sxp_mem_pkg::addr_t'(src);
    dst_base = sxp_mem_pkg::addr_t'(dst);
    length   = sxp_mem_pkg::len_t'(len);
    op       = f;
    operand  = k;
    @(negedge clk);
    start = 1'b0;
    lat   = 1;
    while (done !== 1'b1 && lat < LIMIT)
    begin
      check_flag("busy", busy, 1'b1);
      if (stray && busy === 1'b1)
        drive_stray_strobes();
      @(negedge clk);
      start   = 1'b0;
      host_we = 1'b0;
      host_re = 1'b0;
      lat++;
    end
    if (done !== 1'b1)
      stop_on_timeout("done pulse");
    else
    begin
      check_word("start to done cycles", sxp_mem_pkg::word_t'(lat),
                 sxp_mem_pkg::word_t'((len == 0) ? 2 : len + 3));
      check_flag("busy with done", busy, 1'b1);
      @(negedge clk);
      check_flag("done after its pulse", done, 1'b0);
      check_flag("busy after done", busy, 1'b0);
      for (i = 0; i < len; i++)
        shadow[dst + i] = ref_xform(f, shadow[src + i], k);
      commands++;
    end
  endtask

  task automatic random_command(input sxp_mem_pkg::xform_op_t f, input bit stray);
    int len;
    int lo;
    int hi;
    len = 1 + int'(next_rand() % MAX_LEN);
    lo  = int'(next_rand() % (MEM_WORDS / 2 - len + 1));
    hi  = MEM_WORDS / 2 + int'(next_rand() % (MEM_WORDS / 2 - len + 1));
    if (next_rand() & 32'd1)
      run_command(lo, hi, len, f, next_rand(), stray);
    else
      run_command(hi, lo, len, f, next_rand(), stray);
  endtask

  initial
  begin : main
    int i;
    int err0;
    sxp_mem_pkg::addr_t a;
    reset_b    = 1'b0;
    host_we    = 1'b0;
    host_re    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    start      = 1'b0;
    src_base   = '0;
    dst_base   = '0;
    length     = '0;
    op         = sxp_mem_pkg::OP_PASS;
    operand    = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_b = 1'b1;

    err0 = errors;
    check_flag("busy after reset", busy, 1'b0);
    check_flag("done after reset", done, 1'b0);
    check_flag("host_rvalid after reset", host_rvalid, 1'b0);
    for (i = 0; i < MEM_WORDS; i++)
      host_write(sxp_mem_pkg::addr_t'(i), next_rand());
    settle_writes('0);
    for (i = 0; i < 16; i++)
    begin
      a = sxp_mem_pkg::addr_t'(next_rand());
      host_write(a, next_rand());
      settle_writes(a ^ sxp_mem_pkg::addr_t'(1));
      readback(int'(a), 1);
    end
    readback(0, MEM_WORDS);
    report_test("host write and read", err0);

    err0 = errors;
    for (i = 0; i < 5; i++)
      random_command(sxp_mem_pkg::xform_op_t'(3'(i)), 1'b0);
    readback(0, MEM_WORDS);
    report_test("each operation", err0);

    err0 = errors;
    run_command(16, 600, 0, sxp_mem_pkg::OP_INV, next_rand(), 1'b0);  // no writes
    run_command(700, 40, 1, sxp_mem_pkg::OP_BSWAP, next_rand(), 1'b0);
    readback(0, MEM_WORDS);
    check_word("done pulse count", sxp_mem_pkg::word_t'(done_pulses),
               sxp_mem_pkg::word_t'(commands));
    report_test("done and busy protocol", err0);

    err0 = errors;
    for (i = 0; i < 3; i++)
      random_command(sxp_mem_pkg::xform_op_t'(3'(next_rand() % 5)), 1'b1);
    readback(0, MEM_WORDS);
    report_test("strobes ignored while busy", err0);

    err0 = errors;
    for (i = 0; i < 6; i++)
      random_command(sxp_mem_pkg::xform_op_t'(3'(next_rand() % 5)), 1'b0);
    readback(0, MEM_WORDS);
    check_word("done pulse count", sxp_mem_pkg::word_t'(done_pulses),
               sxp_mem_pkg::word_t'(commands));
    report_test("back to back commands", err0);

    $display("checks %0d, errors %0d, commands %0d", checks, errors, commands);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- block_xform_top.sv
/* block-transform engine top, source and destination ranges must not overlap
   host accesses and start are ignored while busy is high */

`timescale 1ns/100ps

module block_xform_top #(
  parameter int ADDR_WIDTH = sxp_mem_pkg::ADDR_W,
  parameter int MEM_SIZE   = 1024
) (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    host_we,
  input  logic                    host_re,
  input  logic [ADDR_WIDTH-1:0]   host_addr,
  input  sxp_mem_pkg::word_t      host_wdata,
  output sxp_mem_pkg::word_t      host_rdata,
  output logic                    host_rvalid,
  input  logic                    start,
  input  logic [ADDR_WIDTH-1:0]   src_base,
  input  logic [ADDR_WIDTH-1:0]   dst_base,
  input  sxp_mem_pkg::len_t       length,
  input  sxp_mem_pkg::xform_op_t  op,
  input  sxp_mem_pkg::word_t      operand,
  output logic                    busy,
  output logic                    done
);

  logic [ADDR_WIDTH-1:0]  addra;                 // port a, reads only
  logic [ADDR_WIDTH-1:0]  addrb;                 // port b, writes only
  logic                   web;
  sxp_mem_pkg::word_t     db;
  sxp_mem_pkg::word_t     qa;

  logic                   item_valid;
  logic [ADDR_WIDTH-1:0]  item_dst;
  logic                   item_last;
  sxp_mem_pkg::xform_op_t item_op;
  sxp_mem_pkg::word_t     item_operand;
  sxp_mem_pkg::word_t     item_wdata;
  logic                   item_host;

  logic                   wb_valid;
  logic [ADDR_WIDTH-1:0]  wb_addr;
  sxp_mem_pkg::word_t     wb_data;
  logic                   wb_last;

  assign host_rdata = qa;                        // host read shares port a

  fetch_addr_gen #(.ADDR_WIDTH(ADDR_WIDTH)) u_fetch (
    .clk(clk), .reset_b(reset_b),
    .start(start), .src_base(src_base), .dst_base(dst_base),
    .length(length), .op(op), .operand(operand),
    .host_we(host_we), .host_re(host_re), .host_addr(host_addr),
    .host_wdata(host_wdata), .done(done),
    .busy(busy), .host_rvalid(host_rvalid), .addra(addra),
    .item_valid(item_valid), .item_dst(item_dst), .item_last(item_last),
    .item_op(item_op), .item_operand(item_operand),
    .item_wdata(item_wdata), .item_host(item_host)
  );

  dpmem #(.ADDR_WIDTH(ADDR_WIDTH), .MEM_SIZE(MEM_SIZE)) u_mem (
    .clk(clk), .reset_b(reset_b),
    .addra(addra), .addrb(addrb),
    .wea(1'b0), .web(web),                       // port a never writes
    .da('0), .db(db),
    .qa(qa), .qb()                               // port b read side unused by the engine
  );

  word_alu u_alu (
    .clk(clk), .reset_b(reset_b), .qa(qa),
    .item_valid(item_valid), .item_dst(item_dst), .item_last(item_last),
    .item_op(item_op), .item_operand(item_operand),
    .item_wdata(item_wdata), .item_host(item_host),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_last(wb_last)
  );

  write_back #(.ADDR_WIDTH(ADDR_WIDTH)) u_wb (
    .clk(clk), .reset_b(reset_b),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_last(wb_last),
    .addrb(addrb), .web(web), .db(db), .done(done)
  );

endmodule

//--- dpmem.sv
/* behavioral dual-port word memory, contents not cleared by reset
   read of an address the other port writes in the same cycle returns x */

`timescale 1ns/100ps

module dpmem #(
  parameter int ADDR_WIDTH = sxp_mem_pkg::ADDR_W,
  parameter int MEM_SIZE   = 1024
) (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic [ADDR_WIDTH-1:0]  addra,      // port a address
  input  logic [ADDR_WIDTH-1:0]  addrb,      // port b address
  input  logic                   wea,        // port a write enable
  input  logic                   web,        // port b write enable
  input  sxp_mem_pkg::word_t     da,         // port a write data
  input  sxp_mem_pkg::word_t     db,         // port b write data
  output sxp_mem_pkg::word_t     qa,         // port a read data, one cycle late
  output sxp_mem_pkg::word_t     qb          // port b read data, one cycle late
);

  sxp_mem_pkg::word_t mem [0:MEM_SIZE-1];    // storage array

  sxp_mem_pkg::word_t rd_a;                  // registered read a
  sxp_mem_pkg::word_t rd_b;                  // registered read b

  logic in_range_a;                          // addra inside the array
  logic in_range_b;                          // addrb inside the array
  logic same_addr;                           // both ports on one word

  assign in_range_a = (addra < MEM_SIZE);
  assign in_range_b = (addrb < MEM_SIZE);
  assign same_addr  = (addra == addrb);

  // port a read, unknown on collision with a port b write
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      rd_a <= 'x;                            // no valid data after reset
    else if (same_addr && web)
      rd_a <= 'x;
    else if (in_range_a)
      rd_a <= mem[addra];
    else
      rd_a <= 'x;                            // nothing stored out there
  end

  // port b read, same rule mirrored
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      rd_b <= 'x;
    else if (same_addr && wea)
      rd_b <= 'x;
    else if (in_range_b)
      rd_b <= mem[addrb];
    else
      rd_b <= 'x;
  end

  // writes, out of range ones are dropped
  always_ff @(posedge clk)
  begin
    if (wea && in_range_a)
      mem[addra] <= da;
    if (web && in_range_b)
      mem[addrb] <= db;                      // b wins a same-word double write
  end

  assign qa = rd_a;
  assign qb = rd_b;

endmodule

//--- fetch_addr_gen.sv
/* command sequencer and host port, one source address per cycle on port a
   host strobes and start are only honoured in ST_IDLE; start beats a host strobe */

`timescale 1ns/100ps

module fetch_addr_gen #(
  parameter int ADDR_WIDTH = sxp_mem_pkg::ADDR_W
) (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    start,         // command strobe
  input  logic [ADDR_WIDTH-1:0]   src_base,
  input  logic [ADDR_WIDTH-1:0]   dst_base,
  input  sxp_mem_pkg::len_t       length,
  input  sxp_mem_pkg::xform_op_t  op,
  input  sxp_mem_pkg::word_t      operand,
  input  logic                    host_we,       // host write strobe
  input  logic                    host_re,       // host read strobe
  input  logic [ADDR_WIDTH-1:0]   host_addr,
  input  sxp_mem_pkg::word_t      host_wdata,
  input  logic                    done,          // from write back
  output logic                    busy,
  output logic                    host_rvalid,   // qa holds host read data
  output logic [ADDR_WIDTH-1:0]   addra,
  output logic                    item_valid,    // item carries a write
  output logic [ADDR_WIDTH-1:0]   item_dst,
  output logic                    item_last,     // final item of a command
  output sxp_mem_pkg::xform_op_t  item_op,
  output sxp_mem_pkg::word_t      item_operand,
  output sxp_mem_pkg::word_t      item_wdata,
  output logic                    item_host      // data comes from item_wdata
);

  sxp_mem_pkg::fetch_state_t state;
  sxp_mem_pkg::len_t         remain;             // items left after the current one
  logic [ADDR_WIDTH-1:0]     src_ptr;            // source address of current item

  logic idle;
  logic cmd_go;                                  // accepted start
  logic host_wr;                                 // accepted host write
  logic host_rd;                                 // accepted host read
  logic short_cmd;                               // length 0 or 1

  assign idle      = (state == sxp_mem_pkg::ST_IDLE);
  assign cmd_go    = idle && start;
  assign host_wr   = idle && !start && host_we;
  assign host_rd   = idle && !start && host_re;
  assign short_cmd = (length < sxp_mem_pkg::len_t'(2));

  assign busy  = !idle;
  assign addra = idle ? host_addr : src_ptr;     // host read goes straight to the ram

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state       <= sxp_mem_pkg::ST_IDLE;
      remain      <= '0;
      item_valid  <= 1'b0;
      item_last   <= 1'b0;
      item_host   <= 1'b0;
      host_rvalid <= 1'b0;
    end
    else
    begin
      host_rvalid <= host_rd;
      case (state)
        sxp_mem_pkg::ST_IDLE:
        begin
          item_valid <= cmd_go ? (length != '0) : host_wr;
          item_last  <= cmd_go && short_cmd;     // zero length sends a bare last marker
          item_host  <= host_wr;
          if (cmd_go)
          begin
            remain <= length - sxp_mem_pkg::len_t'(1);
            state  <= short_cmd ? sxp_mem_pkg::ST_DRAIN : sxp_mem_pkg::ST_RUN;
          end
        end
        sxp_mem_pkg::ST_RUN:
        begin
          item_valid <= 1'b1;
          item_last  <= (remain == sxp_mem_pkg::len_t'(1));
          item_host  <= 1'b0;
          remain     <= remain - sxp_mem_pkg::len_t'(1);
          if (remain == sxp_mem_pkg::len_t'(1))
            state <= sxp_mem_pkg::ST_DRAIN;      // final address issued
        end
        sxp_mem_pkg::ST_DRAIN:
        begin
          item_valid <= 1'b0;
          item_last  <= 1'b0;
          item_host  <= 1'b0;
          if (done)
            state <= sxp_mem_pkg::ST_IDLE;
        end
        default:
          state <= sxp_mem_pkg::ST_IDLE;
      endcase
    end
  end

  // item payload and pointers
  always_ff @(posedge clk)
  begin
    if (cmd_go)
    begin
      src_ptr      <= src_base;
      item_dst     <= dst_base;
      item_op      <= op;
      item_operand <= operand;
    end
    else if (host_wr)
    begin
      item_dst   <= host_addr;
      item_wdata <= host_wdata;
      item_op    <= sxp_mem_pkg::OP_PASS;        // host write is a plain copy
    end
    else if (state == sxp_mem_pkg::ST_RUN)
    begin
      src_ptr  <= src_ptr + 1'b1;
      item_dst <= item_dst + 1'b1;
    end
  end

endmodule

//--- sxp_mem_pkg.sv
/* shared types for the block-transform engine and its testbench
   ADDR_W sets the default address width, len_t must hold a full memory count */

package sxp_mem_pkg;

  localparam int WORD_W = 32;                 // data word width
  localparam int ADDR_W = 10;                 // default word address width
  localparam int LEN_W  = ADDR_W + 1;         // one extra bit so 1024 fits

  typedef logic [WORD_W-1:0] word_t;          // memory data word
  typedef logic [ADDR_W-1:0] addr_t;          // word address
  typedef logic [LEN_W-1:0]  len_t;           // element count of a command

  // transform applied to each source word
  typedef enum logic [2:0] {
    OP_PASS  = 3'd0,                          // copy unchanged
    OP_ADD   = 3'd1,                          // word + operand
    OP_XOR   = 3'd2,                          // word ^ operand
    OP_INV   = 3'd3,                          // bitwise invert
    OP_BSWAP = 3'd4                           // reverse byte order
  } xform_op_t;

  // command sequencer states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,                          // host port open
    ST_RUN   = 2'd1,                          // issuing source addresses
    ST_DRAIN = 2'd2                           // waiting for done from write back
  } fetch_state_t;

endpackage

//--- tb.f
sxp_mem_pkg.sv
dpmem.sv
fetch_addr_gen.sv
word_alu.sv
write_back.sv
block_xform_top.sv
block_xform_sva.sv
block_xform_tb.sv

//--- word_alu.sv
/* aligns the item tag with ram read data and applies the transform
   a last marker without a valid item bypasses both stages so done comes early */

`timescale 1ns/100ps

module word_alu (
  input  logic                    clk,
  input  logic                    reset_b,
  input  sxp_mem_pkg::word_t      qa,            // ram port a data
  input  logic                    item_valid,
  input  sxp_mem_pkg::addr_t      item_dst,
  input  logic                    item_last,
  input  sxp_mem_pkg::xform_op_t  item_op,
  input  sxp_mem_pkg::word_t      item_operand,
  input  sxp_mem_pkg::word_t      item_wdata,
  input  logic                    item_host,
  output logic                    wb_valid,
  output sxp_mem_pkg::addr_t      wb_addr,
  output sxp_mem_pkg::word_t      wb_data,
  output logic                    wb_last
);

  logic                   v_q;                   // tag delayed to meet qa
  logic                   last_q;
  logic                   host_q;
  sxp_mem_pkg::addr_t     dst_q;
  sxp_mem_pkg::xform_op_t op_q;
  sxp_mem_pkg::word_t     operand_q;
  sxp_mem_pkg::word_t     wdata_q;
  logic                   wb_last_q;             // last of a real write
  sxp_mem_pkg::word_t     src_word;

  function automatic sxp_mem_pkg::word_t apply_op(
    input sxp_mem_pkg::xform_op_t f,
    input sxp_mem_pkg::word_t     w,
    input sxp_mem_pkg::word_t     k
  );
    case (f)
      sxp_mem_pkg::OP_ADD:   apply_op = w + k;
      sxp_mem_pkg::OP_XOR:   apply_op = w ^ k;
      sxp_mem_pkg::OP_INV:   apply_op = ~w;
      sxp_mem_pkg::OP_BSWAP: apply_op = {w[7:0], w[15:8], w[23:16], w[31:24]};
      default:               apply_op = w;       // pass and unused codes
    endcase
  endfunction

  assign src_word = host_q ? wdata_q : qa;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      v_q       <= 1'b0;
      last_q    <= 1'b0;
      host_q    <= 1'b0;
      wb_valid  <= 1'b0;
      wb_last_q <= 1'b0;
    end
    else
    begin
      v_q       <= item_valid;
      last_q    <= item_valid && item_last;      // marker not carried here
      host_q    <= item_host;
      wb_valid  <= v_q;
      wb_last_q <= v_q && last_q;
    end
  end

  always_ff @(posedge clk)
  begin
    dst_q     <= item_dst;
    op_q      <= item_op;
    operand_q <= item_operand;
    wdata_q   <= item_wdata;
    wb_addr   <= dst_q;
    wb_data   <= apply_op(op_q, src_word, operand_q);
  end

  // zero length command, marker reaches write back in the cycle it is issued
  assign wb_last = wb_last_q || (item_last && !item_valid);

endmodule

//--- write_back.sv
/* drives ram port b from the alu result, one write per valid item
   done pulses one cycle after the last item, with or without a write */

`timescale 1ns/100ps

module write_back #(
  parameter int ADDR_WIDTH = sxp_mem_pkg::ADDR_W
) (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   wb_valid,       // result to store
  input  logic [ADDR_WIDTH-1:0]  wb_addr,
  input  sxp_mem_pkg::word_t     wb_data,
  input  logic                   wb_last,        // end of command
  output logic [ADDR_WIDTH-1:0]  addrb,
  output logic                   web,
  output sxp_mem_pkg::word_t     db,
  output logic                   done
);

  // write lands on the edge closing this cycle
  assign addrb = wb_addr;
  assign db    = wb_data;
  assign web   = wb_valid;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      done <= 1'b0;
    else
      done <= wb_last;                           // last write or bare zero length marker
  end

endmodule
